/* compile.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/microcode_rom.sv
verilog/sequencer.sv
verilog/alu.sv
verilog/datapath.sv
verilog/cpu_top.sv
sim/cpu_props.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cpu testbench with Verilator, run it, then scan the log
verilator --binary --assert --top-module cpu_tb -f compile.f -o cpu_sim > sim.log 2>&1 &&
    ./obj_dir/cpu_sim >> sim.log 2>&1
grep -q "Test failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no pass line, see sim.log"; exit 1; }
echo "simulation passed"

/* sim/cpu_props.sv */
`timescale 1ns/1ns

// memory bus and halt rules on the core boundary
module cpu_props (
    input logic clk,
    input logic rst,
    input logic mem_we,
    input logic halted
);

    no_write_when_halted: assert property (
        @(posedge clk) disable iff (rst) halted |-> !mem_we
    ) else $error("mem_we high while halted");

    halt_is_sticky: assert property (
        @(posedge clk) disable iff (rst) halted |=> halted
    ) else $error("halted dropped without a reset");

    // first cycle out of reset is a fetch
    idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !mem_we
    ) else $error("mem_we high in the cycle after reset");

endmodule

bind cpu_top cpu_props u_props (
    .clk    (clk),
    .rst    (rst),
    .mem_we (mem_we),
    .halted (halted)
);

/* sim/cpu_tb.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int          NUM_RANDOM     = 20;
    localparam int          NUM_RUNS       = NUM_RANDOM + 3;
    localparam int          MAX_PROG_WORDS = 160;
    localparam int          TIMEOUT_CYCLES = NUM_RUNS * MAX_PROG_WORDS * 10 + 2000;
    localparam logic [15:0] RES_BASE       = 16'h00F8;  // r0..r7 land here

    logic                   clk;
    logic                   rst;
    logic [`CPU_WORD_W-1:0] mem_rdata;
    logic [`CPU_WORD_W-1:0] mem_addr;
    logic [`CPU_WORD_W-1:0] mem_wdata;
    logic                   mem_we;
    logic                   halted;

    logic [15:0] prog [256];
    logic [15:0] mem  [256];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int          plen;
    int          wr_idx;
    int          cycles;

    cpu_top UUT (
        .clk       (clk),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .halted    (halted)
    );

    always #50 clk = ~clk;

    // ==================================================
    // memory model, reloaded from prog during reset
    // ==================================================
    assign mem_rdata = mem[mem_addr[7:0]];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++)
                mem[i] <= prog[i];
        end else if (mem_we) begin
            mem[mem_addr[7:0]] <= mem_wdata;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        if (got !== want)
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, want));
    endtask

    // every store is compared in order against the prediction
    always @(negedge clk) begin
        if (rst) begin
            wr_idx <= 0;
        end else if (mem_we) begin
            if (wr_idx >= exp_addr.size()) begin
                abort_run("memory write beyond the predicted list");
            end else begin
                check_value("mem_addr", mem_addr, exp_addr[wr_idx]);
                check_value("mem_wdata", mem_wdata, exp_data[wr_idx]);
                wr_idx <= wr_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
            abort_run("timeout, the core did not halt in time");
    end

    // ==================================================
    // reference model of the instruction set
    // ==================================================
    function automatic void predict_writes();
        logic [15:0] m [256];
        logic [15:0] r [8];
        logic [15:0] pc, iw, res;
        logic [5:0]  op;
        logic [2:0]  x, y;
        logic        z, c, take;
        for (int i = 0; i < 256; i++)
            m[i] = prog[i];
        for (int i = 0; i < 8; i++)
            r[i] = 16'h0;
        pc = 16'h0;
        z = 1'b0;
        c = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        for (int s = 0; s < 1000; s++) begin
            iw = m[pc[7:0]];
            pc = pc + 16'd1;
            op = iw[15:10];
            x  = iw[9:7];
            y  = iw[6:4];
            if (op == OP_HALT)
                break;
            case (op)
                OP_NOT, OP_AND, OP_OR, OP_XOR, OP_ADD, OP_SUB, OP_CMP: begin
                    c = 1'b0;  // logic ops clear carry
                    case (op)
                        OP_NOT:  res = ~r[x];
                        OP_AND:  res = r[x] & r[y];
                        OP_OR:   res = r[x] | r[y];
                        OP_XOR:  res = r[x] ^ r[y];
                        OP_ADD:  {c, res} = {1'b0, r[x]} + {1'b0, r[y]};
                        default: {c, res} = {1'b0, r[x]} - {1'b0, r[y]};  // sub and cmp
                    endcase
                    z = (res == 16'h0);
                    if (op != OP_CMP)
                        r[x] = res;
                end
                OP_JMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC: begin
                    case (op)
                        OP_JZ:   take = z;
                        OP_JNZ:  take = !z;
                        OP_JC:   take = c;
                        OP_JNC:  take = !c;
                        default: take = 1'b1;
                    endcase
                    pc = take ? m[pc[7:0]] : pc + 16'd1;
                end
                OP_MOV: r[x] = r[y];
                OP_LD:  r[x] = m[r[y][7:0]];
                OP_LDI: begin
                    r[x] = m[pc[7:0]];
                    pc   = pc + 16'd1;
                end
                OP_ST: begin
                    m[r[x][7:0]] = r[y];
                    exp_addr.push_back(r[x]);
                    exp_data.push_back(r[y]);
                end
                default: ;  // undefined opcode does nothing
            endcase
        end
    endfunction

    // ==================================================
    // program builder
    // ==================================================
    function automatic logic [15:0] enc(input logic [5:0] op, input logic [2:0] x,
                                        input logic [2:0] y);
        return {op, x, y, 4'b0000};
    endfunction

    task automatic emit(input logic [15:0] w);
        prog[plen[7:0]] = w;
        plen++;
    endtask

    task automatic emit_ldi(input logic [2:0] x, input logic [15:0] v);
        emit(enc(OP_LDI, x, 3'd0));
        emit(v);
    endtask

    // jump whose target lies just past the one skipped word
    task automatic emit_skip_jump(input logic [5:0] op, input logic [15:0] skipped);
        emit(enc(op, 3'd0, 3'd0));
        emit(16'(plen + 2));
        emit(skipped);
    endtask

    task automatic clear_prog();
        for (int i = 0; i < 256; i++)
            prog[i] = {i[7:0], ~i[7:0]};
        plen = 0;
    endtask

    task automatic store_results();
        for (int i = 0; i < 7; i++) begin
            emit_ldi(3'd7, RES_BASE + 16'(i));
            emit(enc(OP_ST, 3'd7, 3'(i)));
        end
        emit_ldi(3'd0, RES_BASE + 16'd7);
        emit(enc(OP_ST, 3'd0, 3'd7));
        emit(enc(OP_HALT, 3'd0, 3'd0));
    endtask

    function automatic logic [5:0] pick_alu_op();
        case ($urandom % 7)
            0:       return OP_NOT;
            1:       return OP_AND;
            2:       return OP_OR;
            3:       return OP_XOR;
            4:       return OP_ADD;
            5:       return OP_SUB;
            default: return OP_CMP;
        endcase
    endfunction

    function automatic logic [5:0] pick_jump_op();
        case ($urandom % 5)
            0:       return OP_JMP;
            1:       return OP_JZ;
            2:       return OP_JNZ;
            3:       return OP_JC;
            default: return OP_JNC;
        endcase
    endfunction

    function automatic logic [15:0] data_addr();
        return 16'h00C0 + 16'($urandom % 32);
    endfunction

    task automatic build_alu_prog();
        clear_prog();
        emit_ldi(3'd1, 16'h1234);
        emit_ldi(3'd2, 16'h0F0F);
        emit(enc(OP_MOV, 3'd3, 3'd1));
        emit(enc(OP_ADD, 3'd3, 3'd2));
        emit(enc(OP_MOV, 3'd4, 3'd1));
        emit(enc(OP_SUB, 3'd4, 3'd2));
        emit(enc(OP_MOV, 3'd5, 3'd1));
        emit(enc(OP_AND, 3'd5, 3'd2));
        emit(enc(OP_MOV, 3'd6, 3'd1));
        emit(enc(OP_OR, 3'd6, 3'd2));
        emit(enc(OP_XOR, 3'd1, 3'd2));
        emit(enc(OP_NOT, 3'd2, 3'd0));
        store_results();
    endtask

    task automatic build_jump_prog();
        clear_prog();
        emit_ldi(3'd1, 16'hFFFF);
        emit_ldi(3'd2, 16'h0001);
        emit(enc(OP_ADD, 3'd1, 3'd2));   // z=1 c=1
        emit_skip_jump(OP_JZ, enc(OP_NOT, 3'd3, 3'd0));
        emit_skip_jump(OP_JC, enc(OP_NOT, 3'd5, 3'd0));
        emit_skip_jump(OP_JNC, enc(OP_NOT, 3'd6, 3'd0));
        emit_skip_jump(OP_JNZ, enc(OP_NOT, 3'd4, 3'd0));  // z cleared by the not
        emit_ldi(3'd1, 16'h0005);
        emit_ldi(3'd2, 16'h0007);
        emit(enc(OP_SUB, 3'd1, 3'd2));   // borrow
        emit_skip_jump(OP_JC, enc(OP_NOT, 3'd3, 3'd0));
        emit_skip_jump(OP_JNZ, enc(OP_NOT, 3'd5, 3'd0));
        emit_skip_jump(OP_JZ, enc(OP_NOT, 3'd4, 3'd0));
        emit(enc(OP_CMP, 3'd2, 3'd2));   // z=1 c=0
        emit_skip_jump(OP_JNC, enc(OP_NOT, 3'd5, 3'd0));
        emit_skip_jump(OP_JNZ, enc(OP_NOT, 3'd6, 3'd0));
        emit_skip_jump(OP_JC, enc(OP_NOT, 3'd3, 3'd0));
        emit_skip_jump(OP_JMP, enc(OP_NOT, 3'd0, 3'd0));
        store_results();
    endtask

    task automatic build_mem_prog();
        clear_prog();
        emit_ldi(3'd1, 16'h00E0);
        emit_ldi(3'd2, 16'hBEEF);
        emit(enc(OP_ST, 3'd1, 3'd2));
        emit_ldi(3'd3, 16'h00E1);
        emit(enc(OP_ST, 3'd3, 3'd1));
        emit(enc(OP_LD, 3'd4, 3'd1));    // reads back beef
        emit(enc(OP_LD, 3'd5, 3'd3));
        emit(enc(6'd2, 3'd4, 3'd5));     // undefined opcodes
        emit(enc(6'd63, 3'd4, 3'd4));
        emit(enc(OP_LD, 3'd6, 3'd7));
        store_results();
    endtask

    task automatic build_random();
        int         n;
        logic [2:0] x, y;
        clear_prog();
        for (int i = 0; i < 8; i++)
            emit_ldi(3'(i), 16'($urandom));
        n = 10 + int'($urandom % 21);
        for (int k = 0; k < n; k++) begin
            x = 3'($urandom);
            y = 3'($urandom);
            case ($urandom % 10)
                0, 1, 2, 3: emit(enc(pick_alu_op(), x, y));
                4:          emit(enc(OP_MOV, x, y));
                5:          emit_ldi(x, 16'($urandom));
                6: begin
                    emit_ldi(x, data_addr());
                    emit(enc(OP_ST, x, y));
                end
                7: begin
                    emit_ldi(y, data_addr());
                    emit(enc(OP_LD, x, y));
                end
                8:          emit_skip_jump(pick_jump_op(), enc(pick_alu_op(), x, y));
                default:    emit(enc(6'd2 + 6'($urandom % 2), x, y));
            endcase
        end
        store_results();
    endtask

    // ==================================================
    // run control
    // ==================================================
    task automatic run_program();
        predict_writes();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("mem_we", 16'(mem_we), 16'h0);
        check_value("halted", 16'(halted), 16'h0);
        while (!halted)
            @(negedge clk);
        check_value("write count", 16'(wr_idx), 16'(exp_addr.size()));
        repeat (10) @(negedge clk);  // core must stay parked
        check_value("halted", 16'(halted), 16'h1);
        check_value("write count", 16'(wr_idx), 16'(exp_addr.size()));
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        cycles = 0;
        void'($urandom(32'ha8dce426));
        build_alu_prog();
        run_program();
        build_jump_prog();
        run_program();
        build_mem_prog();
        run_program();
        repeat (NUM_RANDOM) begin
            build_random();
            run_program();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module alu import cpu_pkg::*; (
    input  alu_op_t                op,
    input  logic [`CPU_WORD_W-1:0] a,
    input  logic [`CPU_WORD_W-1:0] b,
    output logic [`CPU_WORD_W-1:0] result,
    output logic                   carry
);

    always_comb begin
        result = '0;
        carry  = 1'b0;  // stays clear for logic ops
        case (op)
            ALU_NOT: result = ~a;
            ALU_ADD: {carry, result} = {1'b0, a} + {1'b0, b};
            ALU_SUB: {carry, result} = {1'b0, a} - {1'b0, b};  // top bit is the borrow
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: ;
        endcase
    end

endmodule

/* verilog/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// width of data words and of memory addresses
`define CPU_WORD_W 16

// width of the micro-pc into the microcode ROM
`define CPU_UPC_W 8

// number of general registers in the register file
`define CPU_NREGS 8

// micro address that ends the current instruction
`define CPU_UPC_END 255

`endif

/* verilog/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

    // ==================================================
    // instruction set
    // ==================================================
    typedef enum logic [5:0] {
        OP_HALT = 6'd0,
        OP_NOT  = 6'd4,
        OP_AND  = 6'd7,
        OP_OR   = 6'd8,
        OP_XOR  = 6'd9,
        OP_ADD  = 6'd10,
        OP_SUB  = 6'd12,
        OP_CMP  = 6'd16,
        OP_JMP  = 6'd23,
        OP_JZ   = 6'd24,
        OP_JNZ  = 6'd25,
        OP_JC   = 6'd26,
        OP_JNC  = 6'd27,
        OP_MOV  = 6'd32,
        OP_LD   = 6'd33,
        OP_LDI  = 6'd35,
        OP_ST   = 6'd37
    } opcode_t;

    typedef enum logic [2:0] {PH_FETCH, PH_FETCH_1, PH_DECODE, PH_MICRO, PH_HALT} cpu_phase_t;

    // ==================================================
    // micro-word fields
    // ==================================================
    typedef enum logic [2:0] {
        BUS_NONE, BUS_REG, BUS_TMP, BUS_SUM, BUS_IX, BUS_IY, BUS_MEM, BUS_PC
    } bus_sel_t;

    typedef enum logic [3:0] {
        DST_NONE, DST_A, DST_B, DST_REG, DST_TMP,
        DST_MAR, DST_PC, DST_RSEL, DST_SUM, DST_MEM
    } reg_dst_t;

    typedef enum logic [2:0] {ALU_NOP, ALU_NOT, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_t;

    typedef enum logic [2:0] {FLOW_NONE, FLOW_PC_INC, FLOW_DONE, FLOW_HALT, FLOW_FLAGS} flow_t;

    typedef struct packed {
        logic [`CPU_UPC_W-1:0] next_upc;  // END finishes the instruction
        bus_sel_t              bus;
        reg_dst_t              dst;
        alu_op_t               alu;
        flow_t                 flow;
    } micro_word_t;

endpackage

/* verilog/cpu_top.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_WORD_W-1:0] mem_rdata,
    output logic [`CPU_WORD_W-1:0] mem_addr,
    output logic [`CPU_WORD_W-1:0] mem_wdata,
    output logic                   mem_we,
    output logic                   halted
);

    opcode_t opcode;
    logic    z_flag;
    logic    c_flag;

    ctrl_if ctl ();

    sequencer u_seq (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .z_flag (z_flag),
        .c_flag (c_flag),
        .ctl    (ctl.sequencer),
        .halted (halted)
    );

    datapath u_dp (
        .clk       (clk),
        .rst       (rst),
        .ctl       (ctl.datapath),
        .mem_rdata (mem_rdata),
        .opcode    (opcode),
        .z_flag    (z_flag),
        .c_flag    (c_flag),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

endmodule

/* verilog/ctrl_if.sv */
`timescale 1ns/1ns

// control word from the sequencer, applied by the datapath each cycle
interface ctrl_if import cpu_pkg::*; ();

    cpu_phase_t phase;
    bus_sel_t   bus_sel;
    reg_dst_t   reg_dst;
    alu_op_t    alu_op;
    flow_t      flow;

    modport sequencer (
        output phase, bus_sel, reg_dst, alu_op, flow
    );

    modport datapath (
        input phase, bus_sel, reg_dst, alu_op, flow
    );

endinterface

/* verilog/datapath.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module datapath import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    ctrl_if.datapath               ctl,
    input  logic [`CPU_WORD_W-1:0] mem_rdata,
    output opcode_t                opcode,
    output logic                   z_flag,
    output logic                   c_flag,
    output logic [`CPU_WORD_W-1:0] mem_addr,
    output logic [`CPU_WORD_W-1:0] mem_wdata,
    output logic                   mem_we
);

    localparam int W     = `CPU_WORD_W;
    localparam int SEL_W = $clog2(`CPU_NREGS);

    // ==================================================
    // registers and bus
    // ==================================================
    logic [W-1:0]     pc, ir, mar;
    logic [W-1:0]     tmp, a_reg, b_reg, sum;
    logic [SEL_W-1:0] reg_sel;
    logic [W-1:0]     regs [`CPU_NREGS];
    logic [W-1:0]     bus;
    logic [W-1:0]     alu_result;
    logic             alu_carry;
    logic [SEL_W-1:0] rx, ry;

    assign opcode = opcode_t'(ir[W-1 -: 6]);
    assign rx     = ir[9:7];
    assign ry     = ir[6:4];

    alu u_alu (
        .op     (ctl.alu_op),
        .a      (a_reg),
        .b      (b_reg),
        .result (alu_result),
        .carry  (alu_carry)
    );

    always_comb begin
        case (ctl.bus_sel)
            BUS_REG: bus = regs[reg_sel];
            BUS_TMP: bus = tmp;
            BUS_SUM: bus = sum;
            BUS_IX:  bus = {{(W - SEL_W){1'b0}}, rx};  // register index, not value
            BUS_IY:  bus = {{(W - SEL_W){1'b0}}, ry};
            BUS_MEM: bus = mem_rdata;
            BUS_PC:  bus = pc;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= '0;
            ir      <= '0;
            mar     <= '0;
            tmp     <= '0;
            a_reg   <= '0;
            b_reg   <= '0;
            sum     <= '0;
            reg_sel <= '0;
            z_flag  <= 1'b0;
            c_flag  <= 1'b0;
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end else begin
            case (ctl.phase)
                PH_FETCH:   mar <= pc;
                PH_FETCH_1: begin
                    ir <= mem_rdata;
                    pc <= pc + 1;  // past the opcode word
                end
                default: ;
            endcase
            if (ctl.flow == FLOW_PC_INC)
                pc <= pc + 1;
            if (ctl.flow == FLOW_FLAGS) begin
                z_flag <= (alu_result == '0);
                c_flag <= alu_carry;
            end
            case (ctl.reg_dst)
                DST_A:    a_reg <= bus;
                DST_B:    b_reg <= bus;
                DST_REG:  regs[reg_sel] <= bus;
                DST_TMP:  tmp <= bus;
                DST_MAR:  mar <= bus;
                DST_PC:   pc <= bus;       // jump target
                DST_RSEL: reg_sel <= bus[SEL_W-1:0];
                DST_SUM:  sum <= alu_result;
                default:  ;                // memory write goes out on the bus
            endcase
        end
    end

    // memory side
    assign mem_addr  = mar;
    assign mem_wdata = bus;
    assign mem_we    = (ctl.reg_dst == DST_MEM);

endmodule

/* verilog/microcode_rom.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module microcode_rom import cpu_pkg::*; (
    input  logic [`CPU_UPC_W-1:0] upc,
    output micro_word_t           word
);

    localparam logic [`CPU_UPC_W-1:0] UPC_END = `CPU_UPC_END;

    function automatic micro_word_t mw(input logic [`CPU_UPC_W-1:0] nxt, input bus_sel_t bus,
                                       input reg_dst_t dst, input alu_op_t alu,
                                       input flow_t flow);
        return '{nxt, bus, dst, alu, flow};
    endfunction

    // body shared by rx op ry and cmp, step index counted from base
    function automatic micro_word_t bin_step(input logic [`CPU_UPC_W-1:0] addr,
                                             input logic [`CPU_UPC_W-1:0] base,
                                             input alu_op_t op, input logic [2:0] last);
        logic [`CPU_UPC_W-1:0] ofs;
        logic [`CPU_UPC_W-1:0] nxt;
        micro_word_t           w;
        ofs = addr - base;
        nxt = (ofs[2:0] == last) ? UPC_END : addr + 1;
        case (ofs[2:0])
            3'd0:    w = mw(nxt, BUS_REG, DST_A, ALU_NOP, FLOW_NONE);     // rx -> a
            3'd1:    w = mw(nxt, BUS_IY, DST_RSEL, ALU_NOP, FLOW_NONE);
            3'd2:    w = mw(nxt, BUS_REG, DST_B, ALU_NOP, FLOW_NONE);     // ry -> b
            3'd3:    w = mw(nxt, BUS_NONE, DST_SUM, op, FLOW_FLAGS);
            3'd4:    w = mw(nxt, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            default: w = mw(nxt, BUS_SUM, DST_REG, ALU_NOP, FLOW_NONE);   // sum -> rx
        endcase
        return w;
    endfunction

    always_comb begin
        word = mw(UPC_END, BUS_NONE, DST_NONE, ALU_NOP, FLOW_DONE);  // trap
        case (upc) inside
            8'd0:   word = mw(UPC_END, BUS_NONE, DST_NONE, ALU_NOP, FLOW_HALT);

            // ==================================================
            // alu instructions
            // ==================================================
            8'd4:   word = mw(8'd80, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd80:  word = mw(8'd81, BUS_REG, DST_A, ALU_NOP, FLOW_NONE);
            8'd81:  word = mw(8'd82, BUS_NONE, DST_SUM, ALU_NOT, FLOW_FLAGS);
            8'd82:  word = mw(UPC_END, BUS_SUM, DST_REG, ALU_NOP, FLOW_NONE);

            8'd7:   word = mw(8'd92, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd8:   word = mw(8'd99, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd9:   word = mw(8'd106, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd10:  word = mw(8'd113, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd12:  word = mw(8'd127, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd16:  word = mw(8'd155, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);

            [8'd92:8'd97]:   word = bin_step(upc, 8'd92, ALU_AND, 3'd5);
            [8'd99:8'd104]:  word = bin_step(upc, 8'd99, ALU_OR, 3'd5);
            [8'd106:8'd111]: word = bin_step(upc, 8'd106, ALU_XOR, 3'd5);
            [8'd113:8'd118]: word = bin_step(upc, 8'd113, ALU_ADD, 3'd5);
            [8'd127:8'd132]: word = bin_step(upc, 8'd127, ALU_SUB, 3'd5);
            [8'd155:8'd158]: word = bin_step(upc, 8'd155, ALU_SUB, 3'd3);  // cmp, flags only

            // ==================================================
            // jumps and moves
            // ==================================================
            [8'd23:8'd27]: word = mw(8'd207, BUS_PC, DST_MAR, ALU_NOP, FLOW_NONE);
            8'd207: word = mw(UPC_END, BUS_MEM, DST_PC, ALU_NOP, FLOW_NONE);

            8'd32:  word = mw(8'd208, BUS_IY, DST_RSEL, ALU_NOP, FLOW_NONE);     // mov
            8'd208: word = mw(8'd209, BUS_REG, DST_TMP, ALU_NOP, FLOW_NONE);
            8'd209: word = mw(8'd210, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd210: word = mw(UPC_END, BUS_TMP, DST_REG, ALU_NOP, FLOW_NONE);

            8'd33:  word = mw(8'd212, BUS_IY, DST_RSEL, ALU_NOP, FLOW_NONE);     // ld
            8'd212: word = mw(8'd213, BUS_REG, DST_MAR, ALU_NOP, FLOW_NONE);
            8'd213: word = mw(8'd214, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd214: word = mw(UPC_END, BUS_MEM, DST_REG, ALU_NOP, FLOW_NONE);

            8'd35:  word = mw(8'd225, BUS_PC, DST_MAR, ALU_NOP, FLOW_NONE);      // ldi
            8'd225: word = mw(8'd226, BUS_MEM, DST_TMP, ALU_NOP, FLOW_PC_INC);
            8'd226: word = mw(8'd227, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd227: word = mw(UPC_END, BUS_TMP, DST_REG, ALU_NOP, FLOW_NONE);

            8'd37:  word = mw(8'd234, BUS_IX, DST_RSEL, ALU_NOP, FLOW_NONE);     // st
            8'd234: word = mw(8'd235, BUS_REG, DST_MAR, ALU_NOP, FLOW_NONE);
            8'd235: word = mw(8'd236, BUS_IY, DST_RSEL, ALU_NOP, FLOW_NONE);
            8'd236: word = mw(UPC_END, BUS_REG, DST_MEM, ALU_NOP, FLOW_NONE);
            default: ;
        endcase
    end

endmodule

/* verilog/sequencer.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module sequencer import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  opcode_t   opcode,
    input  logic      z_flag,
    input  logic      c_flag,
    ctrl_if.sequencer ctl,
    output logic      halted
);

    localparam logic [`CPU_UPC_W-1:0] UPC_END = `CPU_UPC_END;

    cpu_phase_t            phase;
    logic [`CPU_UPC_W-1:0] upc;
    micro_word_t           word;
    logic                  jump_taken;  // high for every non-jump opcode too

    microcode_rom u_rom (
        .upc  (upc),
        .word (word)
    );

    always_comb begin
        case (opcode)
            OP_JZ:   jump_taken = z_flag;
            OP_JNZ:  jump_taken = ~z_flag;
            OP_JC:   jump_taken = c_flag;
            OP_JNC:  jump_taken = ~c_flag;
            default: jump_taken = 1'b1;
        endcase
    end

    // ==================================================
    // phase machine and micro-pc
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= PH_FETCH;
            upc   <= UPC_END;
        end else begin
            case (phase)
                PH_FETCH:   phase <= PH_FETCH_1;
                PH_FETCH_1: phase <= PH_DECODE;
                PH_DECODE: begin
                    if (jump_taken) begin
                        upc   <= {{(`CPU_UPC_W - 6){1'b0}}, opcode};  // dispatch entry
                        phase <= PH_MICRO;
                    end else begin
                        phase <= PH_FETCH;
                    end
                end
                PH_MICRO: begin
                    if (word.flow == FLOW_HALT)
                        phase <= PH_HALT;
                    else if (word.next_upc == UPC_END || word.flow == FLOW_DONE)
                        phase <= PH_FETCH;
                    else
                        upc <= word.next_upc;
                end
                PH_HALT:    phase <= PH_HALT;  // only rst leaves
                default:    phase <= PH_FETCH;
            endcase
        end
    end

    // control word is idle outside MICRO
    always_comb begin
        ctl.phase   = phase;
        ctl.bus_sel = BUS_NONE;
        ctl.reg_dst = DST_NONE;
        ctl.alu_op  = ALU_NOP;
        ctl.flow    = FLOW_NONE;
        if (phase == PH_MICRO) begin
            ctl.bus_sel = word.bus;
            ctl.reg_dst = word.dst;
            ctl.alu_op  = word.alu;
            ctl.flow    = word.flow;
        end else if (phase == PH_DECODE && !jump_taken) begin
            ctl.flow = FLOW_PC_INC;  // step over the target word
        end
    end

    assign halted = (phase == PH_HALT);

endmodule
